// File: src/mcu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the microcontroller subsystem.
// Opcode and core state encodings, the address map of the core bus and
// the bus structs that connect the core, the port block, the shared RAM
// and the main CPU side. Modules import what they need from here.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mcu_pkg;

    // Instruction set, one opcode byte each
    // Operands follow in ROM, low byte first for 16-bit addresses
    typedef enum logic [7:0] {
        NOP  = 8'h00,   // No operands
        LDI  = 8'h01,   // acc = imm8
        LDA  = 8'h02,   // acc = mem[addr16]
        STA  = 8'h03,   // mem[addr16] = acc
        ADDI = 8'h04,   // acc = acc + imm8
        DECA = 8'h05,   // acc = acc - 1
        BNE  = 8'h06,   // Branch to addr16 if acc nonzero
        JMP  = 8'h07,   // pc = addr16
        RTI  = 8'h08,   // Return from NMI handler
        WAI  = 8'h09    // Spin until NMI
    } mcu_opcode_e;

    // Core sequencer states
    typedef enum logic [2:0] {
        FETCH_OP,
        FETCH_LO,
        FETCH_HI,
        MEM_ACCESS,
        NMI_ENTRY,
        HALTED
    } mcu_state_e;

    // Address bits 15:12 that select the shared RAM
    localparam logic [3:0]  SHARED_PAGE = 4'h8;
    // Write-only output port 6
    localparam logic [15:0] PORT6_ADDR  = 16'h0017;
    // NMI handler entry in ROM, reset entry is 0
    localparam logic [13:0] NMI_VECTOR  = 14'h0010;

    // Core data bus
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
        logic        valid;
    } mcu_bus_t;

    // Main CPU access to the shared RAM
    typedef struct packed {
        logic [8:0]  addr;
        logic [7:0]  wdata;
        logic        cs;
        logic        wr;
    } host_bus_t;

endpackage

`default_nettype wire

// File: src/mcu_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-cycle 8-bit accumulator core.
// Fetches opcode and operand bytes from an external ROM through a
// request/ok handshake and stalls until each byte arrives. Loads and
// stores go out on the core data bus. Halt and NMI are taken at
// instruction boundaries, one saved PC serves RTI.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_core #(
    parameter int ROM_AW = 14
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              halt,
    input  logic              nmi,
    output logic              halted,
    output mcu_pkg::mcu_bus_t bus,
    input  logic [7:0]        rdata,
    output logic [ROM_AW-1:0] rom_addr,
    output logic              rom_cs,
    input  logic [7:0]        rom_data,
    input  logic              rom_ok
);
    import mcu_pkg::*;

    mcu_state_e        state;
    mcu_opcode_e       op;
    mcu_opcode_e       rom_op;
    logic [ROM_AW-1:0] pc;
    logic [ROM_AW-1:0] saved_pc;
    logic [ROM_AW-1:0] jump_target;
    logic [7:0]        acc;
    logic              zf;
    logic [7:0]        opnd_lo;
    logic [15:0]       ea;
    logic [7:0]        add_res;
    logic [7:0]        dec_res;
    logic              in_nmi;
    logic              wait_nmi;
    logic              load_pend;
    logic              nmi_take;

    // ROM byte seen as an opcode
    assign rom_op      = mcu_opcode_e'(rom_data);
    // High byte arrives with rom_ok, low byte was kept from FETCH_LO
    assign jump_target = ROM_AW'({rom_data, opnd_lo});
    assign add_res     = acc + rom_data;
    assign dec_res     = acc - 8'd1;
    // No nesting, only one saved PC
    assign nmi_take    = nmi && !in_nmi;

    assign rom_addr    = pc;
    assign halted      = (state == HALTED);

    // Data bus is only active for the single MEM_ACCESS cycle
    assign bus.addr    = ea;
    assign bus.wdata   = acc;
    assign bus.we      = (state == MEM_ACCESS) && (op == STA);
    assign bus.valid   = (state == MEM_ACCESS);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_OP;
            pc        <= '0;
            rom_cs    <= 1'b0;
            acc       <= 8'h00;
            zf        <= 1'b1;
            in_nmi    <= 1'b0;
            wait_nmi  <= 1'b0;
            load_pend <= 1'b0;
        end else begin
            case (state)
                FETCH_OP: begin
                    // Registered RAM data of the last LDA lands here
                    if (load_pend) begin
                        acc       <= rdata;
                        zf        <= (rdata == 8'h00);
                        load_pend <= 1'b0;
                    end
                    if (rom_cs) begin
                        // Waiting on the ROM, decode once the byte arrives
                        if (rom_ok) begin
                            rom_cs <= 1'b0;
                            pc     <= pc + 1'b1;
                            op     <= rom_op;
                            case (rom_op)
                                LDI, ADDI, LDA, STA, BNE, JMP: begin
                                    state <= FETCH_LO;
                                end
                                DECA: begin
                                    acc <= dec_res;
                                    zf  <= (dec_res == 8'h00);
                                end
                                RTI: begin
                                    pc     <= saved_pc;
                                    in_nmi <= 1'b0;
                                end
                                WAI: begin
                                    wait_nmi <= 1'b1;
                                end
                                default: begin
                                    // NOP and undefined codes
                                    state <= FETCH_OP;
                                end
                            endcase
                        end
                    end else begin
                        // Instruction boundary
                        // Halt wins so an NMI during halt waits for release
                        if (halt) begin
                            state <= HALTED;
                        end else if (nmi_take) begin
                            state <= NMI_ENTRY;
                        end else if (!wait_nmi) begin
                            rom_cs <= 1'b1;
                        end
                    end
                end

                FETCH_LO: begin
                    if (!rom_cs) begin
                        rom_cs <= 1'b1;
                    end else if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        pc      <= pc + 1'b1;
                        opnd_lo <= rom_data;
                        case (op)
                            LDI: begin
                                acc   <= rom_data;
                                zf    <= (rom_data == 8'h00);
                                state <= FETCH_OP;
                            end
                            ADDI: begin
                                acc   <= add_res;
                                zf    <= (add_res == 8'h00);
                                state <= FETCH_OP;
                            end
                            default: begin
                                state <= FETCH_HI;
                            end
                        endcase
                    end
                end

                FETCH_HI: begin
                    if (!rom_cs) begin
                        rom_cs <= 1'b1;
                    end else if (rom_ok) begin
                        rom_cs <= 1'b0;
                        pc     <= pc + 1'b1;
                        ea     <= {rom_data, opnd_lo};
                        state  <= FETCH_OP;
                        case (op)
                            LDA, STA: begin
                                state <= MEM_ACCESS;
                            end
                            JMP: begin
                                pc <= jump_target;
                            end
                            BNE: begin
                                if (!zf) begin
                                    pc <= jump_target;
                                end
                            end
                            default: begin
                                state <= FETCH_OP;
                            end
                        endcase
                    end
                end

                MEM_ACCESS: begin
                    // Store completes this cycle, load data comes next cycle
                    load_pend <= (op == LDA);
                    state     <= FETCH_OP;
                end

                NMI_ENTRY: begin
                    saved_pc <= pc;
                    pc       <= ROM_AW'(NMI_VECTOR);
                    in_nmi   <= 1'b1;
                    wait_nmi <= 1'b0;
                    state    <= FETCH_OP;
                end

                HALTED: begin
                    if (!halt) begin
                        state <= FETCH_OP;
                    end
                end

                default: begin
                    state <= FETCH_OP;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/mcu_port_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output port 6 and the main CPU NMI latch.
// Port 6 is written by core stores to its address. Bit 0 arms the NMI
// latch, bit 1 drives the interrupt line to the main CPU. The latch sets
// on a rising edge of nmi_set.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_port_regs (
    input  logic              clk,
    input  logic              reset,
    input  mcu_pkg::mcu_bus_t bus,
    input  logic              nmi_set,
    output logic              nmi,
    output logic              irq_main
);
    import mcu_pkg::*;

    logic [7:0] port6;
    logic       port6_wr;
    logic       nmi_set_d;
    logic       nmi_rise;
    logic       nmi_clr;

    // Full 16-bit decode of the port address
    assign port6_wr = bus.valid && bus.we && (bus.addr == PORT6_ADDR);
    assign nmi_rise = nmi_set && !nmi_set_d;
    // Latch held clear while the firmware keeps bit 0 low
    assign nmi_clr  = !port6[0];
    assign irq_main = port6[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            port6 <= 8'h00;
        end else if (port6_wr) begin
            port6 <= bus.wdata;
        end
    end

    // Edge detect, a held request counts once
    always_ff @(posedge clk) begin
        if (reset) begin
            nmi_set_d <= 1'b0;
        end else begin
            nmi_set_d <= nmi_set;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nmi <= 1'b0;
        end else if (nmi_clr) begin
            nmi <= 1'b0;
        end else if (nmi_rise) begin
            nmi <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/mcu_shared_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512-byte RAM shared by the core and the main CPU.
// Both sides read with one cycle of latency. The core side decodes its
// own page, the host may only write while the core is halted.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_shared_ram (
    input  logic               clk,
    input  mcu_pkg::mcu_bus_t  bus,
    output logic [7:0]         core_rdata,
    input  mcu_pkg::host_bus_t host,
    input  logic               halted,
    output logic [7:0]         host_rdata
);
    import mcu_pkg::*;

    logic [7:0] mem [512];
    logic       core_sel;
    logic       host_we;

    assign core_sel = bus.valid && (bus.addr[15:12] == SHARED_PAGE);
    assign host_we  = host.cs && host.wr && halted;

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < 512; i++) begin
            mem[i] = 8'h00;
        end
    end

    // Core cannot store while halted so the two writes never collide
    always_ff @(posedge clk) begin
        if (core_sel && bus.we) begin
            mem[bus.addr[8:0]] <= bus.wdata;
        end
        if (host_we) begin
            mem[host.addr] <= host.wdata;
        end
    end

    // Core side, reads outside the page return 0
    always_ff @(posedge clk) begin
        core_rdata <= core_sel ? mem[bus.addr[8:0]] : 8'h00;
    end

    always_ff @(posedge clk) begin
        if (host.cs) begin
            host_rdata <= mem[host.addr];
        end
    end

endmodule

`default_nettype wire

// File: src/mcu_subsys.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microcontroller subsystem top level.
// Connects the accumulator core to its program ROM, the port 6 block
// with the NMI latch and the RAM shared with the main CPU. ROM_AW sets
// the program ROM address width.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_subsys #(
    parameter int ROM_AW = 14
) (
    input  logic               clk,
    input  logic               reset,
    input  mcu_pkg::host_bus_t host,
    output logic [7:0]         host_rdata,
    input  logic               halt,
    input  logic               nmi_set,
    output logic               bus_active,
    output logic               irq_main,
    output logic [ROM_AW-1:0]  rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok
);
    import mcu_pkg::*;

    mcu_bus_t   core_bus;
    logic [7:0] core_rdata;
    logic       nmi;
    logic       halted;

    // Main CPU sees core bus activity
    assign bus_active = core_bus.valid;

    mcu_core #(
        .ROM_AW   (ROM_AW)
    ) core_i (
        .clk      (clk),
        .reset    (reset),
        .halt     (halt),
        .nmi      (nmi),
        .halted   (halted),
        .bus      (core_bus),
        .rdata    (core_rdata),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    mcu_port_regs port_regs_i (
        .clk      (clk),
        .reset    (reset),
        .bus      (core_bus),
        .nmi_set  (nmi_set),
        .nmi      (nmi),
        .irq_main (irq_main)
    );

    // Host writes gated by the core's halted output
    mcu_shared_ram shared_ram_i (
        .clk        (clk),
        .bus        (core_bus),
        .core_rdata (core_rdata),
        .host       (host),
        .halted     (halted),
        .host_rdata (host_rdata)
    );

endmodule

`default_nettype wire

// File: tb/mcu_subsys_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the microcontroller subsystem.
// A ROM model with random answer latency serves the firmware image. The
// host commands of the stimulus file are run in order against the DUT.
// Read data and irq_main are compared with the values in the file.
// Run from the project root so the data file paths resolve.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_subsys_tb;
    import mcu_pkg::*;

    localparam int ROM_AW       = 14;
    localparam int RESET_CYCLES = 16;

    logic              clk;
    logic              reset;
    host_bus_t         host;
    logic [7:0]        host_rdata;
    logic              halt;
    logic              nmi_set;
    logic              bus_active;
    logic              irq_main;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_cs;
    logic [7:0]        rom_data = 8'h00;
    logic              rom_ok   = 1'b0;

    // ROM model
    logic [7:0]        rom_mem [0:(1 << ROM_AW)-1];
    logic              rom_busy = 1'b0;
    int                rom_wait = 0;

    // Parsed stimulus with one entry per command line
    logic [7:0]        cmd_code [$];
    int                cmd_a [$];
    int                cmd_b [$];
    string             cmd_name [$];

    int                checks        = 0;
    int                errors        = 0;
    int                tests_done    = 0;
    int                test_err_base = 0;
    int                limit_cycles  = 0;
    logic              bus_seen      = 1'b0;

    mcu_subsys #(
        .ROM_AW     (ROM_AW)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .host       (host),
        .host_rdata (host_rdata),
        .halt       (halt),
        .nmi_set    (nmi_set),
        .bus_active (bus_active),
        .irq_main   (irq_main),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // One request at a time with 0 to 5 extra cycles of latency
    // rom_ok is a one-cycle pulse that ends the request
    always @(posedge clk) begin
        if (reset) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
            rom_wait <= 0;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;
        end else if (rom_busy) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_mem[rom_addr];
                rom_busy <= 1'b0;
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end else if (rom_cs) begin
            rom_busy <= 1'b1;
            rom_wait <= int'($urandom % 6);
        end
    end

    // Loads and stores of the running firmware show on bus_active
    always @(negedge clk) begin
        if (!reset && bus_active === 1'b1) begin
            bus_seen <= 1'b1;
        end
    end

    function automatic string strip_end(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r[r.len()-1] == "\n" || r[r.len()-1] == "\r"
                || r[r.len()-1] == " ")) begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    // Comment and blank lines are skipped
    task automatic load_stimulus(output bit ok);
        int         fd;
        int         n;
        int         a;
        int         b;
        string      line;
        string      name;
        logic [7:0] c;
        ok = 1'b0;
        fd = $fopen("tb/mcu_stimulus.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                c    = line[0];
                a    = 0;
                b    = 0;
                n    = 2;
                name = "";
                if (c inside {"H", "I", "D", "N"}) begin
                    n = $sscanf(line, "%c %d", c, a);
                end else if (c inside {"W", "R"}) begin
                    n = $sscanf(line, "%c %h %h", c, a, b) - 1;
                end else if (c == "T") begin
                    name = strip_end(line.substr(2, line.len() - 1));
                end
                if (n < 2) begin
                    $display("Stimulus line is missing a value: %0s", strip_end(line));
                    ok = 1'b0;
                end
                if (c inside {"H", "W", "R", "N", "D", "I", "T"}) begin
                    cmd_code.push_back(c);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                    cmd_name.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: %0s returned %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_quiet(input string when_text);
        checks++;
        if (bus_active !== 1'b0 || irq_main !== 1'b0) begin
            errors++;
            $display("FAIL t=%0t: bus_active %b irq_main %b %0s, expected both low",
                     $time, bus_active, irq_main, when_text);
        end
    endtask

    task automatic apply_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        @(negedge clk);
        check_quiet("after reset");
    endtask

    task automatic run_command(input int idx);
        host_bus_t req;
        int        a;
        int        b;
        a   = cmd_a[idx];
        b   = cmd_b[idx];
        req = '0;
        case (cmd_code[idx])
            "H": begin
                @(posedge clk);
                halt <= a[0];
            end
            "W": begin
                req.addr  = a[8:0];
                req.wdata = b[7:0];
                req.cs    = 1'b1;
                req.wr    = 1'b1;
                @(posedge clk);
                host <= req;
                @(posedge clk);
                host <= '0;
            end
            "R": begin
                req.addr = a[8:0];
                req.cs   = 1'b1;
                @(posedge clk);
                host <= req;
                @(posedge clk);
                host <= '0;
                // Registered read data is stable by the falling edge
                @(negedge clk);
                check_byte($sformatf("host read 0x%03h", a[8:0]), host_rdata, b[7:0]);
            end
            "N": begin
                @(posedge clk);
                nmi_set <= 1'b1;
                repeat (a) @(posedge clk);
                nmi_set <= 1'b0;
            end
            "D": begin
                repeat (a) @(posedge clk);
            end
            "I": begin
                @(negedge clk);
                checks++;
                if (irq_main !== a[0]) begin
                    errors++;
                    $display("FAIL t=%0t: irq_main is %b, expected %b", $time, irq_main, a[0]);
                end
            end
            "T": begin
                tests_done++;
                if (errors == test_err_base) begin
                    $display("Test %0s: ok", cmd_name[idx]);
                end else begin
                    $display("Test %0s: %0d errors", cmd_name[idx], errors - test_err_base);
                end
                test_err_base = errors;
            end
            default: begin
            end
        endcase
    endtask

    // Limit is the stimulus wait time plus a margin per test
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main_seq
        bit loaded;
        int total_wait;
        int test_count;
        reset      = 1'b1;
        halt       = 1'b1;
        nmi_set    = 1'b0;
        host       = '0;
        total_wait = 0;
        test_count = 0;
        void'($urandom(32'he2cf));
        $readmemh("tb/mcu_program.hex", rom_mem);
        load_stimulus(loaded);
        if (!loaded || cmd_code.size() == 0) begin
            $display("The stimulus file tb/mcu_stimulus.txt could not be used");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            foreach (cmd_code[i]) begin
                if (cmd_code[i] == "D") begin
                    total_wait += cmd_a[i];
                end
                if (cmd_code[i] == "T") begin
                    test_count++;
                end
            end
            limit_cycles = 2 * RESET_CYCLES + total_wait + 2000 * test_count;
            // Core comes out of reset halted
            apply_reset();
            foreach (cmd_code[i]) begin
                run_command(i);
            end
            checks++;
            if (!bus_seen) begin
                errors++;
                $display("FAIL t=%0t: bus_active never went high while the firmware ran",
                         $time);
            end
            $display("Tests: %0d  checks: %0d  errors: %0d", tests_done, checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/mcu_stimulus.txt
# Columns: command letter, then values. Addresses and data in hex, cycles in decimal
# H v halt | W addr data host write | R addr data read and expect | N cycles NMI pulse
# D cycles wait | I v expect irq_main | T name end of test
I 0
R 000 00
R 001 00
R 010 00
T reset_state
# Writes while halted read back, a write while running is dropped
W 000 05
W 0A5 3C
W 1FF C3
R 000 05
R 0A5 3C
R 1FF C3
H 0
D 300
W 0A5 77
R 0A5 3C
T halted_writes
# Firmware keeps byte 0x001 at byte 0x000 plus one
H 1
D 40
R 001 06
W 000 41
H 0
D 300
H 1
D 40
R 001 42
W 000 FF
H 0
D 300
H 1
D 40
R 001 00
T firmware_copy
# Each NMI adds one to byte 0x010, a long pulse counts once
H 0
D 40
N 1
D 400
R 010 01
N 1
D 400
R 010 02
N 60
D 400
R 010 03
T nmi_count
# Odd NMI count leaves irq_main high
I 1
N 1
D 400
I 0
R 010 04
N 1
D 400
I 1
R 010 05
T irq_toggle
# NMI during halt is held and serviced after release
H 1
D 40
N 1
D 100
R 010 05
H 0
D 400
R 010 06
I 0
T halt_vs_nmi

// File: tb/mcu_program.hex
// Firmware image, one instruction per line as opcode byte then operand bytes
// 16-bit operands are low byte first, @ lines set the load address
@0000
01 01       // LDI 0x01
03 17 00    // STA port 6 arms the NMI latch
02 00 80    // LDA shared 0x000
04 01       // ADDI 0x01
03 01 80    // STA shared 0x001
07 05 00    // JMP 0x0005
// NMI handler
@0010
02 10 80    // LDA shared 0x010 NMI count
04 01       // ADDI 0x01
03 10 80    // STA shared 0x010
02 11 80    // LDA shared 0x011 irq flag
06 2C 00    // BNE 0x002C when irq_main is already high
01 02       // LDI 0x02
03 17 00    // STA port 6 clears the latch and raises irq_main
01 03       // LDI 0x03
03 17 00    // STA port 6 rearms the latch
03 11 80    // STA shared 0x011 flag set
08          // RTI
01 00       // LDI 0x00 at 0x002C
03 17 00    // STA port 6 clears the latch and drops irq_main
03 11 80    // STA shared 0x011 flag cleared
01 01       // LDI 0x01
03 17 00    // STA port 6 rearms the latch
08          // RTI

// File: verilog.f
src/mcu_pkg.sv
src/mcu_core.sv
src/mcu_port_regs.sv
src/mcu_shared_ram.sv
src/mcu_subsys.sv
tb/mcu_subsys_tb.sv

// File: Makefile
# Verilator build, run and lint for the microcontroller subsystem
# Run from the project root, the testbench reads its data files from tb/

VERILATOR  ?= verilator
TOP        ?= mcu_subsys_tb
RTL_TOP    ?= mcu_subsys
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
BUILD_ARGS ?= --binary --timing -Wno-fatal -j 0
LINT_ARGS  ?= --lint-only --timing -Wall
PASS_TEXT  ?= ^RESULT: PASS$$

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_ARGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_ARGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
